//--- dqm_top.f
+incdir+include
source/dqm_pkg.sv
source/dqm_regs.sv
source/dqm_fifo.sv
source/dqm_framer.sv
source/dqm_top.sv
verification/dqm_tb.sv

//--- Bender.yml
package:
  name: dqm

export_include_dirs:
  - include

sources:
  - source/dqm_pkg.sv
  - source/dqm_regs.sv
  - source/dqm_fifo.sv
  - source/dqm_framer.sv
  - source/dqm_top.sv
  - target: simulation
    files:
      - verification/dqm_tb.sv

//--- verification/dqm_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "dqm_defs.svh"

module dqm_tb import dqm_pkg::*; ();

  localparam int CLK_PERIOD      = 8;
  localparam int TOTAL_SAMPLES   = 137;
  localparam int NUM_BLOCKS      = 17;
  localparam int WATCHDOG_CYCLES = TOTAL_SAMPLES * 24 + NUM_BLOCKS * 32 + 1500;

  localparam bus_addr_t ADDR_CFG0   = {`DQM_SPACE_BASE, `DQM_WORD_CFG0};
  localparam bus_addr_t ADDR_CFG1   = {`DQM_SPACE_BASE, `DQM_WORD_CFG1};
  localparam bus_addr_t ADDR_STAT   = {`DQM_SPACE_BASE, `DQM_WORD_STAT};
  localparam bus_addr_t ADDR_UNUSED = {`DQM_SPACE_BASE, 4'h3};

  logic      clk = 1'b0;
  logic      rst = 1'b1;
  bus_req_t  bus_req;
  bus_rsp_t  bus_rsp;
  sample_t   sample_in = '0;
  logic      in_valid = 1'b0;
  logic      in_ready;
  out_word_t out_word;
  logic      out_valid;
  logic      out_ready = 1'b0;

  integer    seed = 20;
  sample_t   ref_q[$];     // Samples accepted at the input in order
  bus_data_t shadow_cfg0 = '0;
  bus_data_t shadow_cfg1 = '0;
  int        send_limit = 0;
  int        sent = 0;
  sample_t   next_sample = 16'h0100;
  int        in_count = 0;
  int        data_acc = 0;  // Data words accepted at the output
  int        buffered;
  logic      sink_stall = 1'b0;
  logic      expect_quiet = 1'b1;
  logic      saw_full = 1'b0;
  int        chk_phase = 0;  // 0 to 2 for sync words and 3 for data
  count_t    data_left = '0;
  count_t    blocks_seen = '0;
  count_t    blk_size = '0;
  sample_t   blk_fw1 = '0;
  sample_t   blk_fw2 = '0;
  logic      read_req;

  dqm_top i_dut (
    .clk       (clk),
    .rst       (rst),
    .bus_req   (bus_req),
    .bus_rsp   (bus_rsp),
    .sample_in (sample_in),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_word  (out_word),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  // Byte enable bit k covers data bits 8k+7 to 8k
  function automatic bus_data_t apply_be(input bus_data_t cur, input bus_data_t din,
                                         input byte_en_t be);
    bus_data_t res;
    res = cur;
    for (int k = 0; k < 4; k++) begin
      if (be[k]) res[8*k +: 8] = din[8*k +: 8];
    end
    return res;
  endfunction

  function automatic bus_data_t read_model(input bus_addr_t addr);
    if (addr[12:4] != `DQM_SPACE_BASE) return '0;
    case (addr[3:0])
      `DQM_WORD_CFG0: return shadow_cfg0;
      `DQM_WORD_CFG1: return shadow_cfg1;
      `DQM_WORD_STAT: return {16'h0000, blocks_seen};
      default:        return '0;
    endcase
  endfunction

  task automatic bus_write(input bus_addr_t addr, input bus_data_t data, input byte_en_t be);
    @(posedge clk);
    bus_req <= '{valid: 1'b1, write: 1'b1, addr: addr, wdata: data, be: be};
    @(posedge clk);
    bus_req <= '0;
    if (addr[12:4] == `DQM_SPACE_BASE && addr[3:0] == `DQM_WORD_CFG0) begin
      shadow_cfg0 = apply_be(shadow_cfg0, data, be);
    end else if (addr[12:4] == `DQM_SPACE_BASE && addr[3:0] == `DQM_WORD_CFG1) begin
      shadow_cfg1 = apply_be(shadow_cfg1, data, be);
    end
  endtask

  task automatic check_read(input bus_addr_t addr);
    bus_data_t expected;
    expected = read_model(addr);
    @(posedge clk);
    bus_req <= '{valid: 1'b1, write: 1'b0, addr: addr, wdata: '0, be: '0};
    @(posedge clk);
    bus_req <= '0;
    @(posedge clk);  // Response register is loaded one cycle after the request
    assert (bus_rsp.rdata == expected)
      else fail_run($sformatf("Error: bus_rsp.rdata at addr %h expected %h got %h",
                              addr, expected, bus_rsp.rdata));
  endtask

  task automatic wait_data(input int n);
    wait (data_acc >= n);
    repeat (4) @(posedge clk);
  endtask

  // Sample source with random gaps
  always @(posedge clk) begin
    if (rst) begin
      in_valid <= 1'b0;
    end else begin
      if (!in_ready) saw_full <= 1'b1;
      if (in_valid && in_ready) begin
        ref_q.push_back(sample_in);
        in_count <= in_count + 1;
      end
      if (!in_valid || in_ready) begin
        if (sent < send_limit && ($random(seed) & 3) != 0) begin
          in_valid    <= 1'b1;
          sample_in   <= next_sample;
          next_sample = next_sample + 1'b1;
          sent        = sent + 1;
        end else begin
          in_valid <= 1'b0;
        end
      end
    end
  end

  always @(posedge clk) begin
    if (rst || sink_stall) out_ready <= 1'b0;
    else out_ready <= ($random(seed) & 3) != 0;
  end

  // Expected stream from the block rule and the programmed configuration
  always @(posedge clk) begin
    out_word_t expected;
    if (!rst && out_valid && out_ready) begin
      if (chk_phase == 0) begin
        expected = '{data: shadow_cfg0[31:16], is_sync: 1'b1};
        blk_size <= shadow_cfg0[15:0];
        blk_fw1  <= shadow_cfg1[15:0];
        blk_fw2  <= shadow_cfg1[31:16];
        chk_phase <= 1;
      end else if (chk_phase == 1) begin
        expected = '{data: blk_fw1, is_sync: 1'b1};
        chk_phase <= 2;
      end else if (chk_phase == 2) begin
        expected = '{data: blk_fw2, is_sync: 1'b1};
        data_left <= blk_size;
        chk_phase <= 3;
      end else begin
        assert (ref_q.size() > 0)
          else fail_run("A data word left the framer with no sample waiting for it");
        expected = '{data: ref_q.pop_front(), is_sync: 1'b0};
        data_acc  <= data_acc + 1;
        data_left <= data_left - 1'b1;
        if (data_left == 1) begin
          blocks_seen <= blocks_seen + 1'b1;
          chk_phase   <= 0;
        end
      end
      assert (out_word == expected)
        else fail_run($sformatf("Error: out_word expected %h got %h", expected, out_word));
    end
  end

  assign read_req = bus_req.valid & ~bus_req.write;
  assign buffered = in_count - data_acc - ((out_valid && !out_word.is_sync) ? 1 : 0);

  assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_word))
    else fail_run($sformatf("Error: out_word changed to %h while stalled", out_word));

  assert property (@(posedge clk) disable iff (rst) read_req |=> bus_rsp.rvalid)
    else fail_run($sformatf("Error: bus_rsp.rvalid expected %h got %h", 1'b1, bus_rsp.rvalid));

  assert property (@(posedge clk) disable iff (rst) !read_req |=> !bus_rsp.rvalid)
    else fail_run($sformatf("Error: bus_rsp.rvalid expected %h got %h", 1'b0, bus_rsp.rvalid));

  assert property (@(posedge clk) disable iff (rst) (buffered == `DQM_FIFO_DEPTH) == !in_ready)
    else fail_run($sformatf("Error: in_ready expected %h got %h",
                            buffered != `DQM_FIFO_DEPTH, in_ready));

  assert property (@(posedge clk) disable iff (rst) expect_quiet |-> !out_valid)
    else fail_run($sformatf("Error: out_valid expected %h got %h", 1'b0, out_valid));

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    fail_run("Watchdog expired before all samples came out of the framer");
  end

  initial begin
    bus_req = '0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    send_limit <= 5;  // Held in the buffer while block size is zero

    // Byte lanes and halfword packing
    check_read(ADDR_CFG0);
    bus_write(ADDR_CFG1, 32'hc3d2_e1f0, 4'b0001);
    bus_write(ADDR_CFG1, 32'h1122_3344, 4'b0010);
    bus_write(ADDR_CFG1, 32'hfade_beef, 4'b1010);
    check_read(ADDR_CFG1);
    bus_write(ADDR_CFG0, 32'h4755_0009, 4'b1000);
    bus_write(ADDR_CFG0, 32'hab12_0007, 4'b0100);
    bus_write(ADDR_CFG0, 32'h9999_0003, 4'b0000);
    check_read(ADDR_CFG0);

    // Outside the space and unused offsets
    bus_write(13'h0000, 32'hffff_ffff, 4'hf);
    bus_write(13'h1400, 32'h0001_0001, 4'hf);
    bus_write(ADDR_STAT, 32'h5555_5555, 4'hf);
    bus_write(ADDR_UNUSED, 32'h7777_7777, 4'hf);
    check_read(13'h0000);
    check_read(13'h1400);
    check_read(ADDR_STAT);
    check_read(ADDR_UNUSED);
    check_read({`DQM_SPACE_BASE, 4'hf});
    check_read(ADDR_CFG0);
    check_read(ADDR_CFG1);
    repeat (20) @(posedge clk);

    // Block size 8
    bus_write(ADDR_CFG1, 32'h0b1e_2c3d, 4'hf);
    expect_quiet <= 1'b0;
    bus_write(ADDR_CFG0, 32'h1aca_0008, 4'hf);
    send_limit <= 64;
    wait_data(64);
    check_read(ADDR_STAT);

    // Hold the sink until the buffer fills
    sink_stall <= 1'b1;
    send_limit <= 104;
    wait (saw_full);
    repeat (10) @(posedge clk);
    sink_stall <= 1'b0;
    wait_data(104);

    // New values written in the middle of a block
    send_limit <= 126;
    wait (chk_phase == 3 && data_left <= 6 && data_left != 0);
    @(posedge clk);
    sink_stall <= 1'b1;
    repeat (3) @(posedge clk);
    bus_write(ADDR_CFG1, 32'h2d2d_3e3e, 4'hf);
    bus_write(ADDR_CFG0, 32'h4f4f_0007, 4'hf);
    sink_stall <= 1'b0;
    wait_data(126);
    check_read(ADDR_STAT);

    // Block size zero after the current block
    bus_write(ADDR_CFG0, 32'h0000_0000, 4'b0011);
    send_limit <= 133;
    wait_data(133);
    expect_quiet <= 1'b1;
    send_limit <= TOTAL_SAMPLES;
    repeat (50) @(posedge clk);
    check_read(ADDR_STAT);
    check_read(ADDR_CFG0);

    if (ref_q.size() != TOTAL_SAMPLES - 133) begin
      fail_run($sformatf("Error: ref_q size expected %h got %h",
                         TOTAL_SAMPLES - 133, ref_q.size()));
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- source/dqm_top.sv
`timescale 1ns/10ps
`default_nettype none

module dqm_top import dqm_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  bus_req_t  bus_req,
  output bus_rsp_t  bus_rsp,
  input  sample_t   sample_in,
  input  logic      in_valid,
  output logic      in_ready,
  output out_word_t out_word,
  output logic      out_valid,
  input  logic      out_ready
);

  dqm_cfg_t cfg;
  logic     block_done;
  sample_t  buf_data;
  logic     buf_valid;
  logic     buf_ready;

  dqm_regs i_regs (
    .clk        (clk),
    .rst        (rst),
    .bus_req    (bus_req),
    .bus_rsp    (bus_rsp),
    .cfg        (cfg),
    .block_done (block_done)
  );

  // Sample input buffer
  dqm_fifo i_fifo (
    .clk       (clk),
    .rst       (rst),
    .in_data   (sample_in),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_data  (buf_data),
    .out_valid (buf_valid),
    .out_ready (buf_ready)
  );

  dqm_framer i_framer (
    .clk        (clk),
    .rst        (rst),
    .cfg        (cfg),
    .buf_data   (buf_data),
    .buf_valid  (buf_valid),
    .buf_ready  (buf_ready),
    .out_word   (out_word),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .block_done (block_done)
  );

endmodule

`default_nettype wire

//--- source/dqm_framer.sv
`timescale 1ns/10ps
`default_nettype none

module dqm_framer import dqm_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  dqm_cfg_t  cfg,
  input  sample_t   buf_data,
  input  logic      buf_valid,
  output logic      buf_ready,
  output out_word_t out_word,
  output logic      out_valid,
  input  logic      out_ready,
  output logic      block_done
);

  framer_state_t state;
  framer_state_t state_d;
  dqm_cfg_t      cfg_q;      // Configuration for the current block
  count_t        remaining;  // Data words still to load
  logic          out_last;   // Output register holds the last word of a block
  logic          load_ok;
  logic          take;
  logic          load_en;
  sample_t       load_data;
  logic          load_sync;
  logic          load_last;
  logic          latch_cfg;

  assign load_ok   = ~out_valid | out_ready;
  assign buf_ready = (state == DATA) & load_ok;
  assign take      = buf_valid & buf_ready;

  always_comb begin
    state_d   = state;
    load_en   = 1'b0;
    load_data = buf_data;
    load_sync = 1'b0;
    load_last = 1'b0;
    latch_cfg = 1'b0;
    case (state)
      IDLE: begin
        if (cfg.block_size != '0) begin
          latch_cfg = 1'b1;
          state_d   = SYNC0;
        end
      end
      SYNC0: begin
        if (load_ok) begin
          load_en   = 1'b1;
          load_data = cfg_q.frame_word_0;
          load_sync = 1'b1;
          state_d   = SYNC1;
        end
      end
      SYNC1: begin
        if (load_ok) begin
          load_en   = 1'b1;
          load_data = cfg_q.frame_word_1;
          load_sync = 1'b1;
          state_d   = SYNC2;
        end
      end
      SYNC2: begin
        if (load_ok) begin
          load_en   = 1'b1;
          load_data = cfg_q.frame_word_2;
          load_sync = 1'b1;
          state_d   = DATA;
        end
      end
      DATA: begin
        if (take) begin
          load_en   = 1'b1;
          load_last = (remaining == count_t'(1));
          if (load_last) begin
            // New configuration is picked up at the block boundary
            if (cfg.block_size != '0) begin
              latch_cfg = 1'b1;
              state_d   = SYNC0;
            end else begin
              state_d = IDLE;
            end
          end
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= IDLE;
      remaining <= '0;
    end else begin
      state <= state_d;
      if (state == SYNC2 && load_en) begin
        remaining <= cfg_q.block_size;
      end else if (take) begin
        remaining <= remaining - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (latch_cfg) cfg_q <= cfg;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid  <= 1'b0;
      out_last   <= 1'b0;
      block_done <= 1'b0;
    end else begin
      block_done <= out_valid & out_ready & out_last;
      if (load_en) begin
        out_valid <= 1'b1;
        out_last  <= load_last;
      end else if (out_ready) begin
        out_valid <= 1'b0;
        out_last  <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load_en) out_word <= '{data: load_data, is_sync: load_sync};
  end

endmodule

`default_nettype wire

//--- source/dqm_fifo.sv
`timescale 1ns/10ps
`default_nettype none

`include "dqm_defs.svh"

module dqm_fifo import dqm_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  sample_t in_data,
  input  logic    in_valid,
  output logic    in_ready,
  output sample_t out_data,
  output logic    out_valid,
  input  logic    out_ready
);

  localparam int DEPTH = `DQM_FIFO_DEPTH;
  localparam int AW    = $clog2(DEPTH);
  localparam logic [AW:0] FULL_COUNT = (AW+1)'(DEPTH);
  localparam logic [AW-1:0] LAST_PTR = AW'(DEPTH - 1);

  sample_t       mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          push;
  logic          pop;

  assign in_ready  = (count != FULL_COUNT);
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];  // Head word is always on the output

  assign push = in_valid & in_ready;
  assign pop  = out_valid & out_ready;

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= in_data;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;  // Push and pop together keep the level
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/dqm_regs.sv
`timescale 1ns/10ps
`default_nettype none

`include "dqm_defs.svh"

module dqm_regs import dqm_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  bus_req_t bus_req,
  output bus_rsp_t bus_rsp,
  output dqm_cfg_t cfg,
  input  logic     block_done
);

  logic      in_space;
  logic [3:0] offset;
  logic      wr_en;
  logic      rd_en;
  count_t    block_size;
  sample_t   frame_word_0;
  sample_t   frame_word_1;
  sample_t   frame_word_2;
  count_t    block_count;
  bus_data_t rd_mux;
  logic      rvalid_q;
  bus_data_t rdata_q;

  // Merge one halfword register with a pair of byte enables
  function automatic logic [15:0] lane_merge(
    input logic [15:0] cur,
    input logic [15:0] din,
    input logic [1:0]  en
  );
    logic [15:0] res;
    res = cur;
    if (en[0]) res[7:0] = din[7:0];
    if (en[1]) res[15:8] = din[15:8];
    return res;
  endfunction

  assign in_space = (bus_req.addr[`DQM_ADDR_W-1:4] == `DQM_SPACE_BASE);
  assign offset   = bus_req.addr[3:0];
  assign wr_en    = bus_req.valid & bus_req.write & in_space;
  assign rd_en    = bus_req.valid & ~bus_req.write;

  always_ff @(posedge clk) begin
    if (rst) begin
      block_size   <= '0;
      frame_word_0 <= '0;
      frame_word_1 <= '0;
      frame_word_2 <= '0;
    end else if (wr_en) begin
      case (offset)
        `DQM_WORD_CFG0: begin
          block_size   <= lane_merge(block_size, bus_req.wdata[15:0], bus_req.be[1:0]);
          frame_word_0 <= lane_merge(frame_word_0, bus_req.wdata[31:16], bus_req.be[3:2]);
        end
        `DQM_WORD_CFG1: begin
          frame_word_1 <= lane_merge(frame_word_1, bus_req.wdata[15:0], bus_req.be[1:0]);
          frame_word_2 <= lane_merge(frame_word_2, bus_req.wdata[31:16], bus_req.be[3:2]);
        end
        default: ;  // STAT is read only
      endcase
    end
  end

  // Completed block count wraps at 16 bits
  always_ff @(posedge clk) begin
    if (rst) begin
      block_count <= '0;
    end else if (block_done) begin
      block_count <= block_count + 1'b1;
    end
  end

  always_comb begin
    rd_mux = '0;
    if (in_space) begin
      case (offset)
        `DQM_WORD_CFG0: rd_mux = {frame_word_0, block_size};
        `DQM_WORD_CFG1: rd_mux = {frame_word_2, frame_word_1};
        `DQM_WORD_STAT: rd_mux = {16'h0000, block_count};
        default:        rd_mux = '0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= rd_en;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) rdata_q <= rd_mux;
  end

  assign bus_rsp = '{rvalid: rvalid_q, rdata: rdata_q};

  assign cfg = '{
    block_size:   block_size,
    frame_word_0: frame_word_0,
    frame_word_1: frame_word_1,
    frame_word_2: frame_word_2
  };

endmodule

`default_nettype wire

//--- source/dqm_pkg.sv
`default_nettype none

`include "dqm_defs.svh"

package dqm_pkg;

  typedef logic [`DQM_ADDR_W-1:0] bus_addr_t;    // Word address
  typedef logic [`DQM_DATA_W-1:0] bus_data_t;
  typedef logic [`DQM_DATA_W/8-1:0] byte_en_t;   // One bit per byte lane
  typedef logic [15:0] sample_t;
  typedef logic [15:0] count_t;

  typedef struct packed {
    logic      valid;
    logic      write;
    bus_addr_t addr;
    bus_data_t wdata;
    byte_en_t  be;
  } bus_req_t;

  typedef struct packed {
    logic      rvalid;
    bus_data_t rdata;
  } bus_rsp_t;

  typedef struct packed {
    count_t  block_size;
    sample_t frame_word_0;
    sample_t frame_word_1;
    sample_t frame_word_2;
  } dqm_cfg_t;

  typedef struct packed {
    sample_t data;
    logic    is_sync;
  } out_word_t;

  typedef enum logic [2:0] {IDLE, SYNC0, SYNC1, SYNC2, DATA} framer_state_t;

endpackage

`default_nettype wire

//--- include/dqm_defs.svh
`ifndef DQM_DEFS_SVH
`define DQM_DEFS_SVH

// Register bus
`define DQM_ADDR_W 13
`define DQM_DATA_W 32

// Block decode on addr[12:4]
`define DQM_SPACE_BASE 9'h040

// Word offsets on addr[3:0]
`define DQM_WORD_CFG0 4'h0  // {frame_word_0, block_size}
`define DQM_WORD_CFG1 4'h1  // {frame_word_2, frame_word_1}
`define DQM_WORD_STAT 4'h2  // {16'h0, block_count}

// Sample buffer
`define DQM_FIFO_DEPTH 16

`endif
